// ==== verilog.f ====
+incdir+hdl
+incdir+tb
hdl/ifetch_pkg.sv
hdl/fetch_pc.sv
hdl/return_stack.sv
hdl/branch_predict.sv
hdl/fetch_buffer.sv
hdl/ifetch_top.sv
tb/ifetch_properties.sv
tb/ifetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ifetch_tb -o ifetch_sim
obj_dir/ifetch_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

// ==== tb/ifetch_model.svh ====
// reference model for the fetch testbench: program image, expected fetch stream, return stack
`ifndef IFETCH_MODEL_SVH
`define IFETCH_MODEL_SVH

localparam int PROG_WORDS = 1024;   // indexed by pc bits 11:2
localparam int RS_DEPTH   = 8;

instr_t     prog [PROG_WORDS];      // program memory behind the cache
pc_t        exp_pc;                 // pc the queue should take next
pc_t        rs_mem [RS_DEPTH];      // circular return stack
logic [2:0] rs_ptr;                 // wraps, overflow loses the oldest

// ============================================================
// program image, biased opcode mix
// ============================================================
task automatic fill_program();
	int unsigned pick;
	int          dv;
	opcode_e     op;
	instr_t      w;
	for (int a = 0; a < PROG_WORDS; a++) begin
		w    = $random(seed);                              // random upper fields
		pick = $unsigned($random(seed)) % 100;
		dv   = int'($unsigned($random(seed)) % 48) - 24;  // short hops, loops stay local
		if (pick < 10)
			op = OP_NOP;
		else if (pick < 55)
			op = OP_ALU;
		else if (pick < 72)
			op = OP_BCC;
		else if (pick < 86)
			op = OP_CALL;
		else
			op = OP_RET;
		w[6:0] = op;
		if (op == OP_BCC || op == OP_CALL)
			w[31:12] = 20'(dv);                          // word displacement
		prog[a] = w;
	end
endtask

task automatic model_reset();
	exp_pc = `RESET_PC;
	rs_ptr = 3'd0;
	for (int k = 0; k < RS_DEPTH; k++)
		rs_mem[k] = `RESET_PC;   // empty stack returns to the reset address
endtask

// next expected pc once instruction i at exp_pc is accepted
task automatic model_step(instr_t i);
	logic signed [19:0] d;
	pc_t                hop;
	pc_t                seq;
	d   = i[31:12];
	hop = exp_pc + {{(`ADDR_W-20){d[19]}}, d} * pc_t'(`INSN_LEN);
	seq = exp_pc + pc_t'(`INSN_LEN);
	case (i[6:0])
		OP_BCC:  exp_pc = (d < 0) ? hop : seq;   // backward taken, forward falls through
		OP_CALL: begin
			rs_ptr         = rs_ptr + 3'd1;
			rs_mem[rs_ptr] = seq;                // return lands after the call
			exp_pc         = hop;
		end
		OP_RET: begin
			exp_pc = rs_mem[rs_ptr];
			rs_ptr = rs_ptr - 3'd1;
		end
		default: exp_pc = seq;
	endcase
endtask

`endif

// ==== tb/ifetch_tb.sv ====
// testbench for the fetch unit: clock, reset, cache and queue models
// random stimulus, model compare and the run verdict
`timescale 1ns/1ps
`default_nettype none
`include "ifetch_defines.svh"

module ifetch_tb import ifetch_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int NUM_ACCEPT  = 3000;   // run length in accepted instructions
	localparam int IDLE_LIMIT  = 200;    // cycles without a valid slot
	localparam int MAX_CYCLES  = 40000;
	localparam int QUIET_START = 16;     // no misses until fetch is under way

	logic   clk;
	logic   rst;
	logic   hit;
	instr_t inst0, inst1;
	pc_t    pc;
	pc_t    pc_plus;                     // address of the second cache word
	logic   branchmiss;
	pc_t    misspc;
	logic   slot0_ready, slot1_ready;
	logic   slot0_valid, slot1_valid;
	instr_t slot0_instr, slot1_instr;
	pc_t    slot0_pc, slot1_pc;

	integer seed = 32'hec1e;
	int     accepted;
	int     misses;
	int     cycles;
	int     idle;

	`include "ifetch_model.svh"

	ifetch_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.hit         (hit),
		.inst0       (inst0),
		.inst1       (inst1),
		.pc          (pc),
		.branchmiss  (branchmiss),
		.misspc      (misspc),
		.slot0_ready (slot0_ready),
		.slot1_ready (slot1_ready),
		.slot0_valid (slot0_valid),
		.slot0_instr (slot0_instr),
		.slot0_pc    (slot0_pc),
		.slot1_valid (slot1_valid),
		.slot1_instr (slot1_instr),
		.slot1_pc    (slot1_pc)
	);

	// ============================================================
	// clock and cache
	// ============================================================
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	assign pc_plus = pc + pc_t'(`INSN_LEN);
	assign inst0   = prog[pc[11:2]];      // answered in the same cycle
	assign inst1   = prog[pc_plus[11:2]];

	// ============================================================
	// checks
	// ============================================================
	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_pc(string name, pc_t exp_v, pc_t act_v);
		if (act_v !== exp_v) begin
			$display("Error %s expected %h actual %h", name, exp_v, act_v);
			fail_run();
		end
	endtask

	task automatic check_instr(string name, instr_t exp_v, instr_t act_v);
		if (act_v !== exp_v) begin
			$display("Error %s expected %h actual %h", name, exp_v, act_v);
			fail_run();
		end
	endtask

	// ============================================================
	// stimulus and collection
	// ============================================================
	task automatic drive_cycle();
		int unsigned r;
		r          = $unsigned($random(seed));
		hit        = (r % 4) != 0;                                   // three in four hit
		branchmiss = (accepted >= QUIET_START) && ((r / 4) % 50 == 0);
		if (branchmiss) begin
			misspc      = pc_t'($random(seed)) & ~pc_t'(3);       // word aligned restart
			slot0_ready = 1'b0;                                 // queue holds off on a miss
			slot1_ready = 1'b0;
			exp_pc      = misspc;
			misses++;
		end else begin
			slot0_ready = ($unsigned($random(seed)) % 5) != 0;
			slot1_ready = ($unsigned($random(seed)) % 3) != 0;
		end
	endtask

	task automatic collect_accepts();
		if (slot0_valid) begin
			idle = 0;
		end else begin
			idle++;
			if (idle > IDLE_LIMIT) begin
				$display("Timeout: no valid slot arrived for %0d cycles", IDLE_LIMIT);
				fail_run();
			end
		end
		if (slot0_valid && slot0_ready) begin
			check_pc($sformatf("slot0 pc, insn %0d", accepted), exp_pc, slot0_pc);
			check_instr($sformatf("slot0 instr, insn %0d", accepted),
				prog[exp_pc[11:2]], slot0_instr);
			model_step(prog[exp_pc[11:2]]);
			accepted++;
			// slot 1 only goes together with slot 0
			if (slot1_valid && slot1_ready) begin
				check_pc($sformatf("slot1 pc, insn %0d", accepted), exp_pc, slot1_pc);
				check_instr($sformatf("slot1 instr, insn %0d", accepted),
					prog[exp_pc[11:2]], slot1_instr);
				model_step(prog[exp_pc[11:2]]);
				accepted++;
			end
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		rst         = 1'b1;
		hit         = 1'b0;
		branchmiss  = 1'b0;
		misspc      = '0;
		slot0_ready = 1'b0;
		slot1_ready = 1'b0;
		accepted    = 0;
		misses      = 0;
		cycles      = 0;
		idle        = 0;
		fill_program();
		model_reset();
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		check_pc("pc after reset", `RESET_PC, pc);
		while (accepted < NUM_ACCEPT && cycles < MAX_CYCLES) begin
			@(posedge clk);
			#1;
			drive_cycle();      // inputs settle 1 ns after the edge
			#1;
			collect_accepts();  // accepts land on the next edge
			cycles++;
		end
		if (accepted < NUM_ACCEPT) begin
			$display("Timeout: only %0d of %0d instructions accepted", accepted, NUM_ACCEPT);
			fail_run();
		end else begin
			$display("accepted %0d instructions over %0d cycles, %0d misses",
				accepted, cycles, misses);
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/ifetch_properties.sv ====
// slot hold under back-pressure, slot order and reset assertions, bound into ifetch_top
`timescale 1ns/1ps
`default_nettype none

module ifetch_properties import ifetch_pkg::*; (
	input wire         clk,
	input wire         rst,
	input wire         branchmiss,
	input wire         slot0_ready,
	input wire         slot0_valid,
	input wire instr_t slot0_instr,
	input wire pc_t    slot0_pc,
	input wire         slot1_valid,
	input wire instr_t slot1_instr,
	input wire pc_t    slot1_pc
);

	// slot 1 never runs ahead of slot 0
	a_slot_order: assert property (@(posedge clk) disable iff (rst)
		slot1_valid |-> slot0_valid)
		else $error("slot 1 valid while slot 0 is empty");

	// nothing accepted and no miss, so both slots keep their contents
	a_slot0_hold: assert property (@(posedge clk) disable iff (rst)
		slot0_valid && !slot0_ready && !branchmiss
		|=> slot0_valid && $stable(slot0_pc) && $stable(slot0_instr))
		else $error("slot 0 changed while waiting for the queue");

	a_slot1_hold: assert property (@(posedge clk) disable iff (rst)
		slot1_valid && !slot0_ready && !branchmiss
		|=> slot1_valid && $stable(slot1_pc) && $stable(slot1_instr))
		else $error("slot 1 changed while waiting for the queue");

	a_reset_empty: assert property (@(posedge clk)
		$fell(rst) |-> !slot0_valid && !slot1_valid)
		else $error("slots valid right after reset");

endmodule

bind ifetch_top ifetch_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.branchmiss  (branchmiss),
	.slot0_ready (slot0_ready),
	.slot0_valid (slot0_valid),
	.slot0_instr (slot0_instr),
	.slot0_pc    (slot0_pc),
	.slot1_valid (slot1_valid),
	.slot1_instr (slot1_instr),
	.slot1_pc    (slot1_pc)
);

`default_nettype wire

// ==== hdl/ifetch_top.sv ====
// instruction fetch unit top: pc, fetch buffer, predictor and return stack
`timescale 1ns/1ps
`default_nettype none

module ifetch_top import ifetch_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	// instruction cache
	input  wire         hit,
	input  wire instr_t inst0,
	input  wire instr_t inst1,
	output pc_t         pc,
	// back end restart
	input  wire         branchmiss,
	input  wire pc_t    misspc,
	// instruction queue
	input  wire         slot0_ready,
	input  wire         slot1_ready,
	output logic        slot0_valid,
	output instr_t      slot0_instr,
	output pc_t         slot0_pc,
	output logic        slot1_valid,
	output instr_t      slot1_instr,
	output pc_t         slot1_pc
);

	logic fill;
	logic take0, take1;
	logic redirect;
	pc_t  redirect_pc;
	logic push, pop;
	pc_t  push_pc;
	pc_t  top_pc;

	// ============================================================
	// input side
	// ============================================================
	fetch_pc u_pc (
		.clk         (clk),
		.rst         (rst),
		.branchmiss  (branchmiss),
		.misspc      (misspc),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fill        (fill),
		.pc          (pc)
	);

	// ============================================================
	// buffering, prediction and the queue side
	// ============================================================
	fetch_buffer u_buf (
		.clk         (clk),
		.rst         (rst),
		.hit         (hit),
		.pc          (pc),
		.inst0       (inst0),
		.inst1       (inst1),
		.redirect    (redirect),
		.branchmiss  (branchmiss),
		.slot0_ready (slot0_ready),
		.slot1_ready (slot1_ready),
		.fill        (fill),
		.take0       (take0),
		.take1       (take1),
		.slot0_valid (slot0_valid),
		.slot0_instr (slot0_instr),
		.slot0_pc    (slot0_pc),
		.slot1_valid (slot1_valid),
		.slot1_instr (slot1_instr),
		.slot1_pc    (slot1_pc)
	);

	branch_predict u_bp (
		.take0       (take0),
		.take1       (take1),
		.slot0_instr (slot0_instr),
		.slot1_instr (slot1_instr),
		.slot0_pc    (slot0_pc),
		.slot1_pc    (slot1_pc),
		.top_pc      (top_pc),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.push        (push),
		.pop         (pop),
		.push_pc     (push_pc)
	);

	return_stack u_rsb (
		.clk     (clk),
		.rst     (rst),
		.push    (push),
		.pop     (pop),
		.push_pc (push_pc),
		.top_pc  (top_pc)
	);

endmodule

`default_nettype wire

// ==== hdl/fetch_buffer.sv ====
// two pair fetch buffer with steering bit, fill from the cache and ordered slot outputs
`timescale 1ns/1ps
`default_nettype none
`include "ifetch_defines.svh"

module fetch_buffer import ifetch_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire         hit,          // cache has inst0/inst1 for pc this cycle
	input  wire pc_t    pc,
	input  wire instr_t inst0,        // word at pc
	input  wire instr_t inst1,        // word at pc + insn length
	input  wire         redirect,
	input  wire         branchmiss,
	input  wire         slot0_ready,
	input  wire         slot1_ready,
	output logic        fill,         // pair taken from the cache
	output logic        take0,        // slot 0 accepted by the queue
	output logic        take1,        // slot 1 accepted along with slot 0
	output logic        slot0_valid,
	output instr_t      slot0_instr,
	output pc_t         slot0_pc,
	output logic        slot1_valid,
	output instr_t      slot1_instr,
	output pc_t         slot1_pc
);

	// entries 0/1 are pair A/B, 2/3 are pair C/D
	instr_t     ins [4];        // buffered words
	pc_t        epc [4];        // pc tag per entry
	logic [3:0] v;              // entry valid
	logic       steer;          // 0: A/B is the older pair, 1: C/D

	logic [3:0] ov;             // valid bits in program order, ov[0] oldest
	logic [1:0] s0_idx, s1_idx; // ordered positions of the two oldest
	logic       s0_found, s1_found;
	logic [1:0] p0, p1;         // physical entries behind slot 0 and 1

	logic [3:0] v_acc;          // valid after this cycle's accepts
	logic       old_empty, young_empty;
	logic       steer_acc;
	logic       fill_pair;      // pair the incoming words go to

	// ============================================================
	// slot selection
	// ============================================================
	always_comb begin
		ov = steer ? {v[1:0], v[3:2]} : v;      // rotate so the older pair comes first
		s0_found = 1'b0;
		s1_found = 1'b0;
		s0_idx   = 2'd0;
		s1_idx   = 2'd0;
		for (int k = 0; k < 4; k++) begin
			if (ov[k] && s0_found && !s1_found) begin
				s1_found = 1'b1;                    // next valid after slot 0
				s1_idx   = 2'(k);
			end
			if (ov[k] && !s0_found) begin
				s0_found = 1'b1;                    // oldest valid
				s0_idx   = 2'(k);
			end
		end
		p0 = {s0_idx[1] ^ steer, s0_idx[0]};    // back to physical numbering
		p1 = {s1_idx[1] ^ steer, s1_idx[0]};
	end

	assign slot0_valid = s0_found;
	assign slot0_instr = ins[p0];
	assign slot0_pc    = epc[p0];
	// flow control in slot 0 goes alone, whatever follows may be stomped
	assign slot1_valid = s1_found & ~is_flow_ctrl(slot0_instr);
	assign slot1_instr = ins[p1];
	assign slot1_pc    = epc[p1];

	assign take0 = slot0_valid & slot0_ready;
	assign take1 = take0 & slot1_valid & slot1_ready;  // in order only

	// ============================================================
	// next buffer state
	// ============================================================
	always_comb begin
		v_acc = v;
		if (take0)
			v_acc[p0] = 1'b0;
		if (take1)
			v_acc[p1] = 1'b0;
		old_empty   = ~|(steer ? v_acc[3:2] : v_acc[1:0]);
		young_empty = ~|(steer ? v_acc[1:0] : v_acc[3:2]);
		// older pair drained, younger one takes over
		steer_acc = steer ^ (old_empty & ~young_empty);
		// both empty: fill the older, else the younger is the free one
		fill_pair = (old_empty & young_empty) ? steer_acc : ~steer_acc;
	end

	// room for a pair now, and no flow change pending
	assign fill = hit & ~redirect & ~branchmiss & (~|v[1:0] | ~|v[3:2]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v     <= 4'b0000;
			steer <= 1'b0;
		end else if (branchmiss || redirect) begin
			// redirect comes from the youngest accepted slot, so every
			// remaining entry is on the wrong path
			v     <= 4'b0000;
			steer <= 1'b0;
		end else begin
			v     <= v_acc | (fill ? (fill_pair ? 4'b1100 : 4'b0011) : 4'b0000);
			steer <= steer_acc;
		end
	end

	// payload, written only with its valid bit
	always_ff @(posedge clk) begin
		if (fill) begin
			ins[{fill_pair, 1'b0}] <= inst0;
			epc[{fill_pair, 1'b0}] <= pc;
			ins[{fill_pair, 1'b1}] <= inst1;
			epc[{fill_pair, 1'b1}] <= pc + pc_t'(`INSN_LEN);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/branch_predict.sv ====
// static predictor on accepted slots: taken backward branches, calls and returns
`timescale 1ns/1ps
`default_nettype none
`include "ifetch_defines.svh"

module branch_predict import ifetch_pkg::*; (
	input  wire         take0,
	input  wire         take1,
	input  wire instr_t slot0_instr,
	input  wire instr_t slot1_instr,
	input  wire pc_t    slot0_pc,
	input  wire pc_t    slot1_pc,
	input  wire pc_t    top_pc,       // current return stack entry
	output logic        redirect,
	output pc_t         redirect_pc,
	output logic        push,
	output logic        pop,
	output pc_t         push_pc       // return address of an accepted call
);

	logic   use0, use1;   // which slot holds the instruction acted on
	logic   act;
	instr_t act_instr;
	pc_t    act_pc;

	// ============================================================
	// pick the oldest accepted flow control instruction
	// ============================================================
	always_comb begin
		use0      = take0 & is_flow_ctrl(slot0_instr);
		use1      = take1 & ~is_flow_ctrl(slot0_instr) & is_flow_ctrl(slot1_instr);
		act       = use0 | use1;
		act_instr = use0 ? slot0_instr : slot1_instr;
		act_pc    = use0 ? slot0_pc : slot1_pc;
	end

	// ============================================================
	// prediction
	// ============================================================
	always_comb begin
		redirect    = 1'b0;
		redirect_pc = branch_target(act_pc, act_instr);
		push        = 1'b0;
		pop         = 1'b0;
		push_pc     = act_pc + pc_t'(`INSN_LEN);   // instruction after the call
		if (act) begin
			if (is_ret(act_instr)) begin
				pop         = 1'b1;
				redirect    = 1'b1;
				redirect_pc = top_pc;                 // predicted return address
			end else if (is_call(act_instr)) begin
				push     = 1'b1;
				redirect = 1'b1;
			end else if (is_back_branch(act_instr)) begin
				redirect = 1'b1;                      // loops are taken
			end
			// forward branch: fall through, nothing to do
		end
	end

endmodule

`default_nettype wire

// ==== hdl/return_stack.sv ====
// circular return address stack, push and pop
`timescale 1ns/1ps
`default_nettype none
`include "ifetch_defines.svh"

module return_stack import ifetch_pkg::*; #(
	parameter int DEPTH = `RSB_DEPTH    // power of two, pointer wraps
) (
	input  wire      clk,
	input  wire      rst,
	input  wire      push,
	input  wire      pop,
	input  wire pc_t push_pc,
	output pc_t      top_pc
);

	localparam int PTR_W = $clog2(DEPTH);

	pc_t              stack [DEPTH];
	logic [PTR_W-1:0] ptr;          // entry seen as top of stack
	logic [PTR_W-1:0] ptr_up;

	assign ptr_up = ptr + 1'b1;     // wraps, overflow overwrites the oldest
	assign top_pc = stack[ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
			for (int k = 0; k < DEPTH; k++)
				stack[k] <= `RESET_PC;    // empty stack returns to reset pc
		end else if (push) begin
			ptr           <= ptr_up;
			stack[ptr_up] <= push_pc;
		end else if (pop) begin
			ptr <= ptr - 1'b1;          // underflow wraps too
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_pc.sv ====
// fetch program counter with miss, redirect and sequential next address select
`timescale 1ns/1ps
`default_nettype none
`include "ifetch_defines.svh"

module fetch_pc import ifetch_pkg::*; (
	input  wire      clk,
	input  wire      rst,
	input  wire      branchmiss,   // back end restart
	input  wire pc_t misspc,
	input  wire      redirect,     // predicted taken flow control accepted
	input  wire pc_t redirect_pc,
	input  wire      fill,         // cache pair went into the buffer
	output pc_t      pc            // address of the pair being requested
);

	pc_t pc_next;

	// ============================================================
	// next address, highest priority first
	// ============================================================
	always_comb begin
		pc_next = pc;                                 // hold on miss of cache or full buffer
		if (branchmiss)
			pc_next = misspc;                         // back end knows best
		else if (redirect)
			pc_next = redirect_pc;                    // static prediction
		else if (fill)
			pc_next = pc + pc_t'(2 * `INSN_LEN);      // step over the pair just taken
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= `RESET_PC;
		else
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// ==== hdl/ifetch_pkg.sv ====
// fetch unit types (address, instruction, opcode, displacement) and decode helpers
`default_nettype none
`include "ifetch_defines.svh"

package ifetch_pkg;

	typedef logic [`ADDR_W-1:0] pc_t;     // byte address
	typedef logic [`INSN_W-1:0] instr_t;  // raw instruction word
	typedef logic signed [19:0] disp_t;   // word displacement, bits 31:12

	// opcode lives in bits 6:0
	typedef enum logic [6:0] {
		OP_NOP  = 7'h00,
		OP_ALU  = 7'h01,
		OP_BCC  = 7'h02,  // conditional branch
		OP_CALL = 7'h03,  // always redirects, pushes return address
		OP_RET  = 7'h04   // redirects to popped address
	} opcode_e;

	function automatic logic is_call(instr_t i);
		return i[6:0] == OP_CALL;
	endfunction

	function automatic logic is_ret(instr_t i);
		return i[6:0] == OP_RET;
	endfunction

	// backward conditional branch, predicted taken
	function automatic logic is_back_branch(instr_t i);
		disp_t d;
		d = disp_t'(i[31:12]);
		return (i[6:0] == OP_BCC) && (d < 0);
	endfunction

	// any instruction the predictor looks at
	function automatic logic is_flow_ctrl(instr_t i);
		return (i[6:0] == OP_BCC) || is_call(i) || is_ret(i);
	endfunction

	// pc + disp * insn length, disp sign extended
	function automatic pc_t branch_target(pc_t pc, instr_t i);
		disp_t d;
		pc_t   off;
		d   = disp_t'(i[31:12]);
		off = {{(`ADDR_W-20){d[19]}}, d};
		return pc + off * `INSN_LEN;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/ifetch_defines.svh ====
// fetch unit widths, reset address, return stack depth and instruction length
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// ============================================================
// datapath widths
// ============================================================
`define ADDR_W    32            // byte address width
`define INSN_W    32            // one instruction word

// ============================================================
// fetch behaviour
// ============================================================
`define INSN_LEN  4             // bytes per instruction
`define RESET_PC  32'h0000_1000 // first fetch address out of reset
`define RSB_DEPTH 8             // return stack entries, power of two

`endif
